//--- Bender.yml
package:
  name: gpif2_ingress

sources:
  - files:
      - design/gpif_stream_pkg.sv
      - design/gpif_pkt_pkg.sv
      - design/gpif_axis32_if.sv
      - design/gpif_sync_fifo.sv
      - design/gpif_pkt_checker.sv
      - design/gpif_pack_32to64.sv
      - design/gpif2_ingress.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/gpif2_ingress_tb.sv

//--- design/gpif2_ingress.sv
// FX3 GPIF-II receive path: timing FIFO, burst buffer, packet checker, packer
// burst buffer fill level drives the has-space and nearly-full flags to the GPIF master
`default_nettype none

module gpif2_ingress import gpif_stream_pkg::*; #(
   parameter int FIFO_SIZE = 9
) (
   input  logic              gpif_clk,
   input  logic              i_rst_n,
   // 32-bit stream from the pins
   input  logic [word_w-1:0] i_tdata,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              o_tready,
   // 64-bit stream to the host side
   output logic [out_w-1:0]  o_tdata,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              i_out_tready,
   // flow-control flags and error pulse
   output logic              o_fifo_has_space,
   output logic              o_fifo_nearly_full,
   output logic              o_bus_error
);

   // burst exponent, never deeper than the checker buffer
   localparam int burst_log2 = (FIFO_SIZE < burst_log2_max) ? FIFO_SIZE : burst_log2_max;
   // a full FX3 burst in words
   localparam logic [burst_log2:0] burst_words = {1'b1, {burst_log2{1'b0}}};
   localparam logic [burst_log2:0] nf_level    = (burst_log2 + 1)'(nearly_full_margin);

   logic [burst_log2:0]       burst_space;

   ////////////////////////////////////////////////////////////////////////
   // stream links
   ////////////////////////////////////////////////////////////////////////

   // pins into the timing FIFO
   gpif_axis32_if pin_link ();
   // timing FIFO to burst buffer
   gpif_axis32_if ing_link ();
   // burst buffer to checker
   gpif_axis32_if burst_link ();
   // checker to packer
   gpif_axis32_if chk_link ();

   assign pin_link.tdata  = i_tdata;
   assign pin_link.tlast  = i_tlast;
   assign pin_link.tvalid = i_tvalid;
   assign o_tready        = pin_link.tready;

   ////////////////////////////////////////////////////////////////////////
   // flow-control flags
   ////////////////////////////////////////////////////////////////////////

   // room for one complete burst from the FX3
   assign o_fifo_has_space   = (burst_space >= burst_words);
   // about to fill, GPIF master should stop
   assign o_fifo_nearly_full = (burst_space < nf_level);

   ////////////////////////////////////////////////////////////////////////
   // chain
   ////////////////////////////////////////////////////////////////////////

   // registers the pin side for timing closure, its space count is left open
   gpif_sync_fifo #(.LOG2_DEPTH(timing_fifo_log2)) timing_fifo (
      .i_clk   (gpif_clk),
      .i_rst_n (i_rst_n),
      .s       (pin_link.snk),
      .m       (ing_link.src),
      .o_space ()
   );

   // holds one burst, its fill level feeds the flags
   gpif_sync_fifo #(.LOG2_DEPTH(burst_log2)) burst_buf (
      .i_clk   (gpif_clk),
      .i_rst_n (i_rst_n),
      .s       (ing_link.snk),
      .m       (burst_link.src),
      .o_space (burst_space)
   );

   gpif_pkt_checker #(.FIFO_SIZE(FIFO_SIZE)) pkt_checker (
      .i_clk       (gpif_clk),
      .i_rst_n     (i_rst_n),
      .s           (burst_link.snk),
      .m           (chk_link.src),
      .o_bus_error (o_bus_error)
   );

   gpif_pack_32to64 packer (
      .i_clk    (gpif_clk),
      .i_rst_n  (i_rst_n),
      .s        (chk_link.snk),
      .o_tdata  (o_tdata),
      .o_tlast  (o_tlast),
      .o_tvalid (o_tvalid),
      .i_tready (i_out_tready)
   );

endmodule

`default_nettype wire

//--- design/gpif_axis32_if.sv
// one 32-bit valid/ready stream link between blocks of the receive path
// a word moves on a clock edge where tvalid and tready are both high
`default_nettype none

interface gpif_axis32_if import gpif_stream_pkg::*; ();

   // payload word
   logic [word_w-1:0] tdata;
   // marks the final word of a packet
   logic              tlast;
   // source has a word; tdata/tlast/tvalid hold until taken
   logic              tvalid;
   // sink can take the word this cycle
   logic              tready;

   // upstream side of a link
   modport src (output tdata, tlast, tvalid, input tready);

   // downstream side of a link
   modport snk (input tdata, tlast, tvalid, output tready);

endinterface

`default_nettype wire

//--- design/gpif_pack_32to64.sv
// packs pairs of 32-bit stream words into 64-bit words
// earlier word goes in the low half; a packet ending early pads the high half
`default_nettype none

module gpif_pack_32to64 import gpif_stream_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rst_n,
   gpif_axis32_if.snk        s,
   output logic [out_w-1:0]  o_tdata,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              i_tready
);

   // first word of a pair, waiting for its partner
   logic [word_w-1:0] lo_r;
   logic              have_lo;

   logic              out_free;
   logic              take;

   // output register empty or being emptied this cycle
   assign out_free = !o_tvalid || i_tready;

   // a lone low word only needs the holding register
   assign s.tready = out_free || (!have_lo && !s.tlast);
   assign take     = s.tvalid && s.tready;

   ////////////////////////////////////////////////////////////////////////
   // low half holding register
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (take && !have_lo && !s.tlast) begin
         lo_r <= s.tdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // pair state and output register
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         have_lo  <= 1'b0;
         o_tvalid <= 1'b0;
         o_tlast  <= 1'b0;
         o_tdata  <= '0;
      end else begin
         // drop valid once taken, a new load below overrides
         if (o_tvalid && i_tready) begin
            o_tvalid <= 1'b0;
         end
         if (take) begin
            if (have_lo) begin
               // second word completes the pair
               o_tdata  <= {s.tdata, lo_r};
               o_tlast  <= s.tlast;
               o_tvalid <= 1'b1;
               have_lo  <= 1'b0;
            end else if (s.tlast) begin
               // packet ends on the low half, pad with zero
               o_tdata  <= {{word_w{1'b0}}, s.tdata};
               o_tlast  <= 1'b1;
               o_tvalid <= 1'b1;
            end else begin
               have_lo <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/gpif_pkt_checker.sv
// packet gate that holds each packet until its last word is checked
// header length must match the words seen, otherwise the packet is dropped
// and o_bus_error pulses once
`default_nettype none

module gpif_pkt_checker import gpif_pkt_pkg::*; #(
   parameter int FIFO_SIZE = 9
) (
   input  logic         i_clk,
   input  logic         i_rst_n,
   gpif_axis32_if.snk   s,
   gpif_axis32_if.src   m,
   output logic         o_bus_error
);

   localparam int depth = 1 << FIFO_SIZE;
   // length limits in header field width, max one bit wider for depth 2^16
   localparam logic [16:0] max_len = 17'(depth);
   localparam logic [15:0] min_len = 16'(min_pkt_words);

   // last bit on top of each stored word
   logic [$bits(pkt_word_u):0] mem [depth];

   // one extra bit so full and empty differ
   logic [FIFO_SIZE:0]  wr_ptr;
   // start of the packet being written, everything before is released
   logic [FIFO_SIZE:0]  commit_ptr;
   logic [FIFO_SIZE:0]  rd_ptr;

   // same input word, decoded as header or as raw payload
   pkt_word_u           in_word;

   logic                in_pkt;
   logic                bad_r;
   logic [15:0]         len_r;
   logic [15:0]         cnt_r;
   logic [15:0]         cnt_next;

   logic                full;
   logic                discard;
   logic                take;
   logic                store;
   logic                len_ok;
   logic                pkt_ok;

   ////////////////////////////////////////////////////////////////////////
   // write side decode
   ////////////////////////////////////////////////////////////////////////

   assign in_word = s.tdata;

   assign full = (wr_ptr[FIFO_SIZE] != rd_ptr[FIFO_SIZE]) &&
                 (wr_ptr[FIFO_SIZE-1:0] == rd_ptr[FIFO_SIZE-1:0]);

   // bad header, or already "length" words stored: swallow until tlast
   assign discard = in_pkt && (bad_r || (cnt_r == len_r));

   // dropped words never need room, so an oversize packet can't stall us
   assign s.tready = discard || !full;
   assign take     = s.tvalid && s.tready;

   // header length check, only meaningful on the first word
   assign len_ok = (in_word.hdr.pkt_len >= min_len) &&
                   ({1'b0, in_word.hdr.pkt_len} <= max_len);

   assign store    = take && !discard && (in_pkt || len_ok);
   assign cnt_next = cnt_r + 16'd1;

   // tlast must sit on exactly word number "length"
   // a header carrying tlast is always short, so in_pkt is required
   assign pkt_ok = in_pkt && !discard && (cnt_next == len_r);

   ////////////////////////////////////////////////////////////////////////
   // packet buffer
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (store) begin
         mem[wr_ptr[FIFO_SIZE-1:0]] <= {s.tlast, in_word.raw};
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // packet tracking, commit and rewind
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr      <= '0;
         commit_ptr  <= '0;
         in_pkt      <= 1'b0;
         bad_r       <= 1'b0;
         len_r       <= '0;
         cnt_r       <= '0;
         o_bus_error <= 1'b0;
      end else begin
         // single cycle pulse
         o_bus_error <= 1'b0;
         if (take) begin
            if (s.tlast) begin
               in_pkt <= 1'b0;
               if (pkt_ok) begin
                  // release the whole packet to the reader
                  wr_ptr     <= wr_ptr + 1'b1;
                  commit_ptr <= wr_ptr + 1'b1;
               end else begin
                  // throw away every word of this packet
                  wr_ptr      <= commit_ptr;
                  o_bus_error <= 1'b1;
               end
            end else begin
               in_pkt <= 1'b1;
               if (store) begin
                  wr_ptr <= wr_ptr + 1'b1;
               end
               if (!in_pkt) begin
                  // header word starts a new packet
                  bad_r <= !len_ok;
                  len_r <= in_word.hdr.pkt_len;
                  cnt_r <= 16'd1;
               end else if (store) begin
                  cnt_r <= cnt_next;
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // read side
   ////////////////////////////////////////////////////////////////////////

   // only committed words are visible
   assign m.tvalid          = (rd_ptr != commit_ptr);
   assign {m.tlast, m.tdata} = mem[rd_ptr[FIFO_SIZE-1:0]];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rd_ptr <= '0;
      end else if (m.tvalid && m.tready) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- design/gpif_pkt_pkg.sv
// packet word layout seen on the GPIF receive stream
// first word of a packet is a header, every later word is raw payload
`default_nettype none

package gpif_pkt_pkg;

   ////////////////////////////////////////////////////////////////////////
   // header word
   ////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      // packet type code
      logic [3:0]  pkt_type;
      // rolling sequence number from the host
      logic [11:0] seq_num;
      // length in 32-bit words, header included
      logic [15:0] pkt_len;
   } pkt_hdr_s;

   // one bus word, viewed as header or as plain payload
   typedef union packed {
      pkt_hdr_s    hdr;
      logic [31:0] raw;
   } pkt_word_u;

   ////////////////////////////////////////////////////////////////////////
   // header field limits
   ////////////////////////////////////////////////////////////////////////

   // header plus at least one payload word
   localparam int min_pkt_words = 2;

endpackage

`default_nettype wire

//--- design/gpif_stream_pkg.sv
// stream widths and flow-control thresholds for the GPIF-II receive path
// imported by the stream FIFOs, the 32-to-64 packer and the top level
`default_nettype none

package gpif_stream_pkg;

   // width of one word from the GPIF pins
   localparam int word_w = 32;

   // width of the packed output word, two input words side by side
   localparam int out_w = 64;

   // depth exponent of the small FIFO right behind the I/O pins
   // only there to ease timing closure
   localparam int timing_fifo_log2 = 5;

   // largest FX3 burst exponent the burst buffer must absorb
   localparam int burst_log2_max = 8;

   // nearly-full rises once fewer free entries than this remain
   // i.e. 5 entries left
   localparam int nearly_full_margin = 6;

endpackage

`default_nettype wire

//--- design/gpif_sync_fifo.sv
// single-clock stream FIFO with a registered free-space count
// used both as the pin timing FIFO and as the FX3 burst buffer
`default_nettype none

module gpif_sync_fifo import gpif_stream_pkg::*; #(
   parameter int LOG2_DEPTH = timing_fifo_log2
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   gpif_axis32_if.snk            s,
   gpif_axis32_if.src            m,
   output logic [LOG2_DEPTH:0]   o_space
);

   localparam int depth = 1 << LOG2_DEPTH;
   // space count of an empty FIFO
   localparam logic [LOG2_DEPTH:0] space_empty = {1'b1, {LOG2_DEPTH{1'b0}}};

   // storage, last bit kept on top of each data word
   logic [word_w:0]         mem [depth];

   logic [LOG2_DEPTH-1:0]   wr_ptr;
   logic [LOG2_DEPTH-1:0]   rd_ptr;
   logic [LOG2_DEPTH:0]     space_r;

   logic                    wr_en;
   logic                    rd_en;

   ////////////////////////////////////////////////////////////////////////
   // handshake
   ////////////////////////////////////////////////////////////////////////

   // only back-pressure when every entry is taken
   assign s.tready = (space_r != '0);
   // anything stored is presented
   assign m.tvalid = (space_r != space_empty);

   assign wr_en = s.tvalid && s.tready;
   assign rd_en = m.tvalid && m.tready;

   // head of queue, visible the cycle after it was written
   assign {m.tlast, m.tdata} = mem[rd_ptr];

   assign o_space = space_r;

   ////////////////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= {s.tlast, s.tdata};
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // pointers and free space
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         space_r <= space_empty;
      end else begin
         // pointers wrap naturally at the power-of-two depth
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // write and read together leave the count alone
         case ({wr_en, rd_en})
            2'b10:   space_r <= space_r - 1'b1;
            2'b01:   space_r <= space_r + 1'b1;
            default: space_r <= space_r;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- gpif2_ingress.f
+incdir+test
design/gpif_stream_pkg.sv
design/gpif_pkt_pkg.sv
design/gpif_axis32_if.sv
design/gpif_sync_fifo.sv
design/gpif_pkt_checker.sv
design/gpif_pack_32to64.sv
design/gpif2_ingress.sv
test/gpif2_ingress_tb.sv

//--- test/gpif2_ingress_tasks.svh
// packet sender, model queue and check helpers for the receive path testbench
// included inside the testbench module, works on its signals and counters
`ifndef GPIF2_INGRESS_TASKS_SVH
`define GPIF2_INGRESS_TASKS_SVH

// compare one value, name the test, expected and actual on a mismatch
task automatic check_val(input string what, input longint expected, input longint actual);
   assert (actual == expected) else begin
      check_errors++;
      $display("** Error %s %s: expected %0h, got %0h", test_name, what, expected, actual);
   end
endtask

// offer one word after a random gap, return on the falling edge after it moved
task automatic put_word(input logic [31:0] data, input logic last, input int gap_max);
   int gap;
   gap = (gap_max > 0) ? ($unsigned($random(seed)) % (gap_max + 1)) : 0;
   repeat (gap) begin
      i_tvalid = 1'b0;
      @(negedge gpif_clk);
   end
   i_tdata  = data;
   i_tlast  = last;
   i_tvalid = 1'b1;
   @(posedge gpif_clk);
   while (!o_tready) begin
      @(posedge gpif_clk);
   end
   @(negedge gpif_clk);
   i_tvalid = 1'b0;
endtask

// pairs of words, earlier one low, odd tail padded with zero
task automatic queue_expected();
   int k;
   int n;
   n = pkt_words.size();
   for (k = 0; k < n; k += 2) begin
      if (k + 1 < n) begin
         exp_q.push_back({(k + 2 == n), pkt_words[k + 1], pkt_words[k]});
      end else begin
         exp_q.push_back({1'b1, 32'h0, pkt_words[k]});
      end
   end
endtask

// build header and payload, add the packet to the model if it should pass
task automatic send_pkt(input int len_field, input int n_words, input int gap_max);
   pkt_word_u hdr_w;
   int        k;
   cycle_limit += 4 * n_words;
   hdr_w.hdr.pkt_type = 4'($random(seed));
   hdr_w.hdr.seq_num  = seq_num;
   hdr_w.hdr.pkt_len  = 16'(len_field);
   seq_num++;
   pkt_words.delete();
   pkt_words.push_back(hdr_w.raw);
   for (k = 1; k < n_words; k++) begin
      pkt_words.push_back($random(seed));
   end
   if (len_field >= min_len && len_field <= buf_depth && n_words == len_field) begin
      queue_expected();
   end else begin
      err_expected++;
   end
   for (k = 0; k < n_words; k++) begin
      put_word(pkt_words[k], (k == n_words - 1), gap_max);
   end
endtask

// wait until the model queue is empty, ends on a falling edge
task automatic wait_drain();
   while (exp_q.size() != 0) begin
      @(posedge gpif_clk);
   end
   repeat (4) @(posedge gpif_clk);
   @(negedge gpif_clk);
endtask

// one bad packet then a good one, exactly one error pulse in between
task automatic reject_case(input int len_field, input int n_words);
   send_pkt(len_field, n_words, 0);
   send_pkt(6, 6, 0);
   wait_drain();
   check_val("bus_error pulses", err_expected, err_seen);
endtask

`endif

//--- test/gpif2_ingress_tb.sv
// testbench for the GPIF-II receive path
// sends good and bad packets and checks the 64-bit output against a model queue
`default_nettype none

module gpif2_ingress_tb import gpif_pkt_pkg::*; ();

   // checker buffer exponent, also handed to the DUT
   localparam int fifo_size = 9;
   localparam int buf_depth = 1 << fifo_size;
   // header plus one payload word
   localparam int min_len   = 2;

   // output ready modes
   localparam int ready_on   = 0;
   localparam int ready_rand = 1;
   localparam int ready_off  = 2;

   logic        gpif_clk = 1'b0;
   logic        i_rst_n;
   logic [31:0] i_tdata;
   logic        i_tlast;
   logic        i_tvalid;
   logic        o_tready;
   logic [63:0] o_tdata;
   logic        o_tlast;
   logic        o_tvalid;
   logic        i_out_tready = 1'b1;
   logic        o_fifo_has_space;
   logic        o_fifo_nearly_full;
   logic        o_bus_error;

   integer      seed = 72;
   string       test_name = "reset";
   int          ready_mode = ready_on;
   logic [11:0] seq_num = '0;

   // expected output words, {last, data}
   logic [64:0] exp_q [$];
   // words of the packet being built
   logic [31:0] pkt_words [$];

   int          cycles = 0;
   int          cycle_limit = 2000;
   int          check_errors = 0;
   int          data_errors = 0;
   int          flag_errors = 0;
   int          hold_errors = 0;
   int          err_expected = 0;
   int          err_seen = 0;
   int          space_low_cycle;
   int          tready_low_cycle;

   always #10 gpif_clk = ~gpif_clk;

   gpif2_ingress #(.FIFO_SIZE(fifo_size)) UUT (
      .gpif_clk           (gpif_clk),
      .i_rst_n            (i_rst_n),
      .i_tdata            (i_tdata),
      .i_tlast            (i_tlast),
      .i_tvalid           (i_tvalid),
      .o_tready           (o_tready),
      .o_tdata            (o_tdata),
      .o_tlast            (o_tlast),
      .o_tvalid           (o_tvalid),
      .i_out_tready       (i_out_tready),
      .o_fifo_has_space   (o_fifo_has_space),
      .o_fifo_nearly_full (o_fifo_nearly_full),
      .o_bus_error        (o_bus_error)
   );

   `include "gpif2_ingress_tasks.svh"

   //////////////////////////////////////////////////////////////////////
   // output side: ready pattern, monitor, timeout
   //////////////////////////////////////////////////////////////////////

   // roughly one cycle in four low in random mode
   always @(negedge gpif_clk) begin
      if (ready_mode == ready_rand) begin
         i_out_tready <= (($unsigned($random(seed)) % 4) != 0);
      end else begin
         i_out_tready <= (ready_mode == ready_on);
      end
   end

   always @(posedge gpif_clk) begin : output_monitor
      logic [64:0] exp_w;
      if (i_rst_n) begin
         if (o_bus_error) begin
            err_seen++;
         end
         if (o_tvalid && i_out_tready) begin
            if (exp_q.size() == 0) begin
               data_errors++;
               $display("output word %h arrived with none expected in %s", o_tdata, test_name);
            end else begin
               exp_w = exp_q.pop_front();
               assert ({o_tlast, o_tdata} == exp_w) else begin
                  data_errors++;
                  $display("** Error %s: expected %h, got %h", test_name, exp_w,
                           {o_tlast, o_tdata});
               end
            end
         end
      end
   end

   always @(posedge gpif_clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout in %s after %0d cycles, output stopped moving", test_name, cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   // input can only stall once the burst buffer is about to overflow
   nf_on_stall: assert property (@(posedge gpif_clk) disable iff (!i_rst_n)
      !o_tready |-> o_fifo_nearly_full)
   else begin
      flag_errors++;
      $display("input stalled in %s while nearly-full was low", test_name);
   end

   // an offered output word stays put until taken
   out_hold: assert property (@(posedge gpif_clk) disable iff (!i_rst_n)
      o_tvalid && !i_out_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast))
   else begin
      hold_errors++;
      $display("output word changed before it was taken in %s", test_name);
   end

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin : test_run
      int n;
      int len;
      i_rst_n  = 1'b0;
      i_tdata  = '0;
      i_tlast  = 1'b0;
      i_tvalid = 1'b0;
      repeat (10) @(posedge gpif_clk);
      @(negedge gpif_clk);
      i_rst_n = 1'b1;
      repeat (2) @(negedge gpif_clk);
      // idle state straight out of reset
      check_val("o_tvalid", 0, o_tvalid);
      check_val("o_bus_error", 0, o_bus_error);
      check_val("o_tready", 1, o_tready);
      check_val("o_fifo_has_space", 1, o_fifo_has_space);
      check_val("o_fifo_nearly_full", 0, o_fifo_nearly_full);

      test_name = "even_length";
      send_pkt(2, 2, 0);
      send_pkt(4, 4, 0);
      send_pkt(16, 16, 0);
      wait_drain();

      // last word lands on the low half
      test_name = "odd_length";
      send_pkt(3, 3, 0);
      send_pkt(5, 5, 0);
      send_pkt(17, 17, 0);
      wait_drain();

      test_name = "bad_packets";
      reject_case(1, 3);
      reject_case(16'hffff, 4);
      reject_case(buf_depth + 1, 6);
      // tlast early, then tlast late
      reject_case(8, 5);
      reject_case(6, 9);

      test_name = "random_flow";
      ready_mode = ready_rand;
      for (n = 0; n < 12; n++) begin
         len = min_len + ($unsigned($random(seed)) % 39);
         send_pkt(len, len, 3);
      end
      wait_drain();
      ready_mode = ready_on;

      // more words than the whole path can hold
      test_name = "stall";
      ready_mode = ready_off;
      fork
         begin
            for (n = 0; n < 56; n++) begin
               send_pkt(16, 16, 0);
            end
         end
         begin
            while (o_fifo_has_space) begin
               @(posedge gpif_clk);
            end
            space_low_cycle = cycles;
            while (o_tready) begin
               @(posedge gpif_clk);
            end
            tready_low_cycle = cycles;
            repeat (40) @(posedge gpif_clk);
            @(negedge gpif_clk);
            ready_mode = ready_on;
         end
      join
      wait_drain();
      check_val("has_space fell first", 1, space_low_cycle < tready_low_cycle);
      // burst buffer empty again once everything drained
      check_val("o_fifo_has_space", 1, o_fifo_has_space);
      check_val("o_fifo_nearly_full", 0, o_fifo_nearly_full);

      repeat (20) @(posedge gpif_clk);
      check_val("bus_error pulses", err_expected, err_seen);
      $display("errors: checks %0d, data %0d, flags %0d, hold %0d",
               check_errors, data_errors, flag_errors, hold_errors);
      if (check_errors + data_errors + flag_errors + hold_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire
